// ==== source/bus_pkg.sv ====
package bus_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    typedef logic [ADDR_W-1:0] addr_t;  // Byte address.
    typedef logic [DATA_W-1:0] word_t;
    typedef logic [1:0] size_t;

    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_HALF = 2'd1;
    localparam size_t SIZE_WORD = 2'd2;

    // The memory is indexed by address bits 9 to 2.
    localparam int MEM_WORDS = 256;
    localparam int IDX_W = $clog2(MEM_WORDS);

    typedef logic [IDX_W-1:0] mem_idx_t;

endpackage

// ==== source/ctrl_pkg.sv ====
package ctrl_pkg;

    // Cycles from address acceptance to the data_ok pulse.
    localparam int MEM_LATENCY = 2;
    localparam int CNT_W = $clog2(MEM_LATENCY + 1);

    typedef logic [CNT_W-1:0] lat_cnt_t;

    // HDSK waits for addr_ok, WAIT waits for data_ok.
    typedef enum logic [1:0] {
        IDLE,
        HDSK,
        WAIT
    } fetch_state_t;

    typedef enum logic [1:0] {NONE, INST, DATA} owner_t;

endpackage

// ==== source/inst_fetch.sv ====
`timescale 1ns/1ns

module inst_fetch (
    input  logic           clk,
    input  logic           rst,
    input  logic           is_new_pc,
    input  bus_pkg::addr_t pc,
    output bus_pkg::word_t inst,
    output logic           inst_valid,
    output logic           stall,
    output logic           clr,
    output logic           bus_req,
    output logic           bus_wr,
    output bus_pkg::size_t bus_size,
    output bus_pkg::addr_t bus_addr,
    output bus_pkg::word_t bus_wdata,
    input  bus_pkg::word_t bus_rdata,
    input  logic           bus_addr_ok,
    input  logic           bus_data_ok
);

    ctrl_pkg::fetch_state_t state, state_next;
    bus_pkg::addr_t pc_q;

    // Fetches are always word reads.
    assign bus_wr    = 1'b0;
    assign bus_size  = bus_pkg::SIZE_WORD;
    assign bus_wdata = '0;

    always_ff @(posedge clk) begin
        if (is_new_pc && state == ctrl_pkg::IDLE) begin
            pc_q <= pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ctrl_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        bus_req    = 1'b0;
        bus_addr   = pc_q;
        stall      = 1'b0;
        case (state)
            ctrl_pkg::IDLE: begin
                if (is_new_pc) begin
                    bus_req    = 1'b1;
                    bus_addr   = pc;  // The new PC goes out in the cycle it arrives.
                    stall      = 1'b1;
                    state_next = bus_addr_ok ? ctrl_pkg::WAIT : ctrl_pkg::HDSK;
                end
            end
            ctrl_pkg::HDSK: begin
                bus_req = 1'b1;
                stall   = 1'b1;
                if (bus_addr_ok) begin
                    state_next = ctrl_pkg::WAIT;
                end
            end
            ctrl_pkg::WAIT: begin
                stall = !bus_data_ok;
                if (bus_data_ok) begin
                    state_next = ctrl_pkg::IDLE;
                end
            end
            default: state_next = ctrl_pkg::IDLE;
        endcase
    end

    assign clr        = stall;  // The front end is flushed for as long as it stalls.
    assign inst_valid = (state == ctrl_pkg::WAIT) && bus_data_ok;
    assign inst       = bus_rdata;

endmodule

// ==== source/data_access.sv ====
`timescale 1ns/1ns

module data_access (
    input  logic           clk,
    input  logic           rst,
    input  logic           mem_en,
    input  logic           mem_wr,
    input  bus_pkg::size_t mem_size,
    input  bus_pkg::addr_t mem_addr,
    input  bus_pkg::word_t mem_wdata,
    output bus_pkg::word_t load_data,
    output logic           load_valid,
    output logic           mem_stall,
    output logic           bus_req,
    output logic           bus_wr,
    output bus_pkg::size_t bus_size,
    output bus_pkg::addr_t bus_addr,
    output bus_pkg::word_t bus_wdata,
    input  bus_pkg::word_t bus_rdata,
    input  logic           bus_addr_ok,
    input  logic           bus_data_ok
);

    ctrl_pkg::fetch_state_t state, state_next;
    logic wr_q;
    bus_pkg::size_t size_q;
    bus_pkg::addr_t addr_q;
    bus_pkg::word_t wdata_q;
    bus_pkg::word_t store_data;
    logic start;

    assign start = (state == ctrl_pkg::IDLE) && mem_en;

    always_ff @(posedge clk) begin
        if (start) begin
            wr_q    <= mem_wr;
            size_q  <= mem_size;
            addr_q  <= mem_addr;
            wdata_q <= mem_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ctrl_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // In IDLE the request comes straight from the pipeline, later from the latched copy.
    assign bus_req  = start || (state == ctrl_pkg::HDSK);
    assign bus_wr   = start ? mem_wr : wr_q;
    assign bus_size = start ? mem_size : size_q;
    assign bus_addr = start ? mem_addr : addr_q;
    assign store_data = start ? mem_wdata : wdata_q;

    always_comb begin
        case (bus_size)
            bus_pkg::SIZE_BYTE: bus_wdata = {4{store_data[7:0]}};
            bus_pkg::SIZE_HALF: bus_wdata = {2{store_data[15:0]}};
            default:            bus_wdata = store_data;
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            ctrl_pkg::IDLE: if (mem_en) state_next = bus_addr_ok ? ctrl_pkg::WAIT : ctrl_pkg::HDSK;
            ctrl_pkg::HDSK: if (bus_addr_ok) state_next = ctrl_pkg::WAIT;
            ctrl_pkg::WAIT: if (bus_data_ok) state_next = ctrl_pkg::IDLE;
            default:        state_next = ctrl_pkg::IDLE;
        endcase
    end

    assign mem_stall = bus_req || (state == ctrl_pkg::WAIT && !bus_data_ok);
    assign load_valid = (state == ctrl_pkg::WAIT) && bus_data_ok && !wr_q;

    always_comb begin
        case (size_q)
            bus_pkg::SIZE_BYTE: load_data = {24'd0, bus_rdata[8*addr_q[1:0] +: 8]};
            bus_pkg::SIZE_HALF: load_data = {16'd0, bus_rdata[16*addr_q[1] +: 16]};
            default:            load_data = bus_rdata;
        endcase
    end

endmodule

// ==== source/bus_arbiter.sv ====
`timescale 1ns/1ns

module bus_arbiter (
    input  logic           clk,
    input  logic           rst,
    input  logic           i_req,
    input  logic           i_wr,
    input  bus_pkg::size_t i_size,
    input  bus_pkg::addr_t i_addr,
    input  bus_pkg::word_t i_wdata,
    output bus_pkg::word_t i_rdata,
    output logic           i_addr_ok,
    output logic           i_data_ok,
    input  logic           d_req,
    input  logic           d_wr,
    input  bus_pkg::size_t d_size,
    input  bus_pkg::addr_t d_addr,
    input  bus_pkg::word_t d_wdata,
    output bus_pkg::word_t d_rdata,
    output logic           d_addr_ok,
    output logic           d_data_ok,
    output logic           m_req,
    output logic           m_wr,
    output bus_pkg::size_t m_size,
    output bus_pkg::addr_t m_addr,
    output bus_pkg::word_t m_wdata,
    input  bus_pkg::word_t m_rdata,
    input  logic           m_addr_ok,
    input  logic           m_data_ok
);

    ctrl_pkg::owner_t owner;
    logic idle;

    assign idle = (owner == ctrl_pkg::NONE);

    // Data side wins whenever it requests.
    assign m_req   = idle && (d_req || i_req);
    assign m_wr    = d_req ? d_wr    : i_wr;
    assign m_size  = d_req ? d_size  : i_size;
    assign m_addr  = d_req ? d_addr  : i_addr;
    assign m_wdata = d_req ? d_wdata : i_wdata;

    assign d_addr_ok = idle && d_req && m_addr_ok;
    assign i_addr_ok = idle && !d_req && i_req && m_addr_ok;

    assign d_data_ok = m_data_ok && (owner == ctrl_pkg::DATA);
    assign i_data_ok = m_data_ok && (owner == ctrl_pkg::INST);
    assign d_rdata   = (owner == ctrl_pkg::DATA) ? m_rdata : '0;
    assign i_rdata   = (owner == ctrl_pkg::INST) ? m_rdata : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= ctrl_pkg::NONE;
        end else if (m_data_ok) begin
            owner <= ctrl_pkg::NONE;
        end else if (m_req && m_addr_ok) begin
            owner <= d_req ? ctrl_pkg::DATA : ctrl_pkg::INST;
        end
    end

endmodule

// ==== source/sram_mem.sv ====
`timescale 1ns/1ns

module sram_mem (
    input  logic           clk,
    input  logic           rst,
    input  logic           req,
    input  logic           wr,
    input  bus_pkg::size_t size,
    input  bus_pkg::addr_t addr,
    input  bus_pkg::word_t wdata,
    output bus_pkg::word_t rdata,
    output logic           addr_ok,
    output logic           data_ok
);

    bus_pkg::word_t mem [bus_pkg::MEM_WORDS];
    bus_pkg::mem_idx_t idx;
    ctrl_pkg::lat_cnt_t cnt;
    logic [3:0] be;
    logic accept;

    assign idx     = addr[bus_pkg::IDX_W+1:2];
    assign addr_ok = (cnt == '0);  // Ready whenever nothing is in flight.
    assign accept  = req && addr_ok;
    assign data_ok = (cnt == ctrl_pkg::lat_cnt_t'(1));

    // Byte lanes touched by a write.
    always_comb begin
        case (size)
            bus_pkg::SIZE_BYTE: be = 4'b0001 << addr[1:0];
            bus_pkg::SIZE_HALF: be = addr[1] ? 4'b1100 : 4'b0011;
            default:            be = 4'b1111;
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rdata <= mem[idx];
            if (wr) begin
                for (int i = 0; i < 4; i++) begin
                    if (be[i]) begin
                        mem[idx][8*i +: 8] <= wdata[8*i +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (accept) begin
            cnt <= ctrl_pkg::lat_cnt_t'(ctrl_pkg::MEM_LATENCY);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

// ==== source/mem_subsys_top.sv ====
`timescale 1ns/1ns

module mem_subsys_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           is_new_pc,
    input  bus_pkg::addr_t pc,
    output bus_pkg::word_t inst,
    output logic           inst_valid,
    output logic           stall,
    output logic           clr,
    input  logic           mem_en,
    input  logic           mem_wr,
    input  bus_pkg::size_t mem_size,
    input  bus_pkg::addr_t mem_addr,
    input  bus_pkg::word_t mem_wdata,
    output bus_pkg::word_t load_data,
    output logic           load_valid,
    output logic           mem_stall
);

    logic i_req, i_wr, i_addr_ok, i_data_ok;
    bus_pkg::size_t i_size;
    bus_pkg::addr_t i_addr;
    bus_pkg::word_t i_wdata, i_rdata;

    logic d_req, d_wr, d_addr_ok, d_data_ok;
    bus_pkg::size_t d_size;
    bus_pkg::addr_t d_addr;
    bus_pkg::word_t d_wdata, d_rdata;

    logic m_req, m_wr, m_addr_ok, m_data_ok;
    bus_pkg::size_t m_size;
    bus_pkg::addr_t m_addr;
    bus_pkg::word_t m_wdata, m_rdata;

    inst_fetch u_inst_fetch (
        .clk(clk), .rst(rst), .is_new_pc(is_new_pc), .pc(pc), .inst(inst),
        .inst_valid(inst_valid), .stall(stall), .clr(clr),
        .bus_req(i_req), .bus_wr(i_wr), .bus_size(i_size), .bus_addr(i_addr),
        .bus_wdata(i_wdata), .bus_rdata(i_rdata), .bus_addr_ok(i_addr_ok),
        .bus_data_ok(i_data_ok)
    );

    data_access u_data_access (
        .clk(clk), .rst(rst), .mem_en(mem_en), .mem_wr(mem_wr), .mem_size(mem_size),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .load_data(load_data),
        .load_valid(load_valid), .mem_stall(mem_stall),
        .bus_req(d_req), .bus_wr(d_wr), .bus_size(d_size), .bus_addr(d_addr),
        .bus_wdata(d_wdata), .bus_rdata(d_rdata), .bus_addr_ok(d_addr_ok),
        .bus_data_ok(d_data_ok)
    );

    bus_arbiter u_bus_arbiter (
        .clk(clk), .rst(rst),
        .i_req(i_req), .i_wr(i_wr), .i_size(i_size), .i_addr(i_addr), .i_wdata(i_wdata),
        .i_rdata(i_rdata), .i_addr_ok(i_addr_ok), .i_data_ok(i_data_ok),
        .d_req(d_req), .d_wr(d_wr), .d_size(d_size), .d_addr(d_addr), .d_wdata(d_wdata),
        .d_rdata(d_rdata), .d_addr_ok(d_addr_ok), .d_data_ok(d_data_ok),
        .m_req(m_req), .m_wr(m_wr), .m_size(m_size), .m_addr(m_addr), .m_wdata(m_wdata),
        .m_rdata(m_rdata), .m_addr_ok(m_addr_ok), .m_data_ok(m_data_ok)
    );

    sram_mem u_sram_mem (
        .clk(clk), .rst(rst), .req(m_req), .wr(m_wr), .size(m_size), .addr(m_addr),
        .wdata(m_wdata), .rdata(m_rdata), .addr_ok(m_addr_ok), .data_ok(m_data_ok)
    );

endmodule

// ==== test/mem_subsys_chk.sv ====
`timescale 1ns/1ns

module mem_subsys_chk (
    input logic           clk,
    input logic           rst,
    input logic           i_req,
    input logic           d_req,
    input bus_pkg::addr_t i_addr,
    input bus_pkg::addr_t d_addr,
    input logic           i_addr_ok,
    input logic           d_addr_ok,
    input logic           i_data_ok,
    input logic           d_data_ok
);

    int fails = 0;
    logic i_acc, d_acc;

    assign i_acc = i_req && i_addr_ok;
    assign d_acc = d_req && d_addr_ok;

    // A data_ok belongs to the master that was accepted one memory latency earlier.
    inst_data_ok: assert property (@(posedge clk) disable iff (rst)
        i_data_ok |-> $past(i_acc, ctrl_pkg::MEM_LATENCY))
        else begin fails++; $error("Fetch master saw data_ok without owning the bus"); end

    data_data_ok: assert property (@(posedge clk) disable iff (rst)
        d_data_ok |-> $past(d_acc, ctrl_pkg::MEM_LATENCY))
        else begin fails++; $error("Data master saw data_ok without owning the bus"); end

    inst_latency: assert property (@(posedge clk) disable iff (rst)
        i_acc |-> ##(ctrl_pkg::MEM_LATENCY) i_data_ok)
        else begin fails++; $error("Accepted fetch did not get its data_ok in time"); end

    data_latency: assert property (@(posedge clk) disable iff (rst)
        d_acc |-> ##(ctrl_pkg::MEM_LATENCY) d_data_ok)
        else begin fails++; $error("Accepted data access did not get its data_ok in time"); end

    // Only one transaction may be outstanding.
    one_open: assert property (@(posedge clk) disable iff (rst)
        (i_acc || d_acc) |-> !$past(i_acc || d_acc)
                             && !$past(i_acc || d_acc, ctrl_pkg::MEM_LATENCY))
        else begin fails++; $error("A request was granted while a transaction was open"); end

    inst_hold: assert property (@(posedge clk) disable iff (rst)
        i_req && !i_addr_ok |=> i_req && $stable(i_addr))
        else begin fails++; $error("Fetch request changed before it was accepted"); end

    data_hold: assert property (@(posedge clk) disable iff (rst)
        d_req && !d_addr_ok |=> d_req && $stable(d_addr))
        else begin fails++; $error("Data request changed before it was accepted"); end

endmodule

bind bus_arbiter mem_subsys_chk u_chk (
    .clk(clk), .rst(rst), .i_req(i_req), .d_req(d_req),
    .i_addr(i_addr), .d_addr(d_addr), .i_addr_ok(i_addr_ok), .d_addr_ok(d_addr_ok),
    .i_data_ok(i_data_ok), .d_data_ok(d_data_ok)
);

// ==== test/mem_subsys_tb.sv ====
`timescale 1ns/1ns

module mem_subsys_tb;

    localparam int FETCH_WORDS = 16;  // Words 0 to 15 hold the code region.
    localparam int DATA_BASE = 128;
    localparam int DATA_WORDS = 16;
    localparam int N_SUB = 24;
    localparam int N_PAIR = 6;
    localparam int N_MIX = 30;
    localparam int N_OPS = 2 * FETCH_WORDS + DATA_WORDS + 2 * N_SUB + 2 * N_PAIR + 2 * N_MIX;

    logic clk = 1'b0;
    logic rst;
    logic is_new_pc, mem_en, mem_wr;
    bus_pkg::addr_t pc, mem_addr;
    bus_pkg::size_t mem_size;
    bus_pkg::word_t mem_wdata, inst, load_data;
    logic inst_valid, stall, clr, load_valid, mem_stall;

    bus_pkg::word_t ref_mem [bus_pkg::MEM_WORDS];
    int errors = 0;
    time inst_done_t, data_done_t;
    logic i_pend, d_pend, d_pend_wr;
    logic i_busy, d_busy, d_store, d_done;

    always #4 clk = !clk;

    mem_subsys_top DUT (.*);

    function automatic bus_pkg::addr_t lane_addr(input int idx, input bus_pkg::size_t sz);
        logic [1:0] off;
        off = 2'($urandom);
        if (sz == bus_pkg::SIZE_HALF) off[0] = 1'b0;
        if (sz == bus_pkg::SIZE_WORD) off = 2'b00;
        return bus_pkg::addr_t'({idx[7:0], off});
    endfunction

    // A store replaces only the lanes that its size and offset cover.
    function automatic void apply_store(input bus_pkg::addr_t a, input bus_pkg::size_t sz,
                                        input bus_pkg::word_t wd);
        bus_pkg::word_t mask;
        int sh;
        sh = (sz == bus_pkg::SIZE_WORD) ? 0 : 8 * a[1:0];
        mask = (sz == bus_pkg::SIZE_BYTE) ? 32'hff : (sz == bus_pkg::SIZE_HALF) ? 32'hffff : '1;
        ref_mem[a[9:2]] = (ref_mem[a[9:2]] & ~(mask << sh)) | ((wd & mask) << sh);
    endfunction

    function automatic bus_pkg::word_t predict_load(input bus_pkg::addr_t a,
                                                    input bus_pkg::size_t sz);
        bus_pkg::word_t mask;
        int sh;
        sh = (sz == bus_pkg::SIZE_WORD) ? 0 : 8 * a[1:0];
        mask = (sz == bus_pkg::SIZE_BYTE) ? 32'hff : (sz == bus_pkg::SIZE_HALF) ? 32'hffff : '1;
        return (ref_mem[a[9:2]] >> sh) & mask;
    endfunction

    task automatic fetch(input bus_pkg::addr_t a, input logic check_lat);
        bus_pkg::word_t exp;
        int lat;
        exp = ref_mem[a[9:2]];
        lat = 0;
        @(negedge clk);
        is_new_pc = 1'b1;
        pc = a;
        @(negedge clk);
        is_new_pc = 1'b0;
        do begin
            @(posedge clk);
            lat++;
        end while (!inst_valid);
        inst_done_t = $time;
        assert (inst == exp) else begin
            errors++;
            $error("CHECK FAILED inst at %h: got %h, expected %h", a, inst, exp);
        end
        if (check_lat) begin
            assert (lat == 2) else begin
                errors++;
                $error("Fetch at %h took %0d cycles instead of 2 on an idle bus", a, lat);
            end
        end
    endtask

    task automatic access(input logic wr, input bus_pkg::size_t sz, input bus_pkg::addr_t a,
                          input bus_pkg::word_t wd);
        bus_pkg::word_t exp;
        if (wr) apply_store(a, sz, wd);
        exp = predict_load(a, sz);
        @(negedge clk);
        mem_en = 1'b1;
        mem_wr = wr;
        mem_size = sz;
        mem_addr = a;
        mem_wdata = wd;
        @(negedge clk);
        mem_en = 1'b0;
        do begin
            @(posedge clk);
        end while (wr ? mem_stall : !load_valid);
        data_done_t = $time;
        if (!wr) begin
            assert (load_data == exp) else begin
                errors++;
                $error("CHECK FAILED load_data at %h size %0d: got %h, expected %h",
                       a, sz, load_data, exp);
            end
        end
    endtask

    task automatic random_access();
        bus_pkg::size_t sz;
        int idx;
        sz = bus_pkg::size_t'($urandom_range(0, 2));
        idx = DATA_BASE + $urandom_range(0, DATA_WORDS - 1);
        access(1'($urandom_range(0, 1)), sz, lane_addr(idx, sz), $urandom);
    endtask

    task automatic quiet_check(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            assert (!(stall || clr || mem_stall || inst_valid || load_valid
                      || DUT.i_req || DUT.d_req || DUT.m_data_ok)) else begin
                errors++;
                $error("A control output or bus request was high with no stimulus after reset");
            end
        end
    endtask

    // Stall outputs must cover each access from its start to its completion.
    always @(posedge clk) begin
        if (rst) begin
            i_pend <= 1'b0;
            d_pend <= 1'b0;
        end else begin
            i_busy = is_new_pc || i_pend;
            d_busy = mem_en || d_pend;
            d_store = mem_en ? mem_wr : d_pend_wr;
            d_done = load_valid || (d_store && DUT.d_data_ok);
            assert (!(i_busy && !inst_valid) || (stall && clr)) else begin
                errors++;
                $error("stall or clr was low while a fetch was pending");
            end
            assert (!inst_valid || (!stall && !clr)) else begin
                errors++;
                $error("stall or clr was still high when inst_valid arrived");
            end
            assert (!(d_busy && !d_done) || mem_stall) else begin
                errors++;
                $error("mem_stall was low while a data access was pending");
            end
            assert (!d_done || !mem_stall) else begin
                errors++;
                $error("mem_stall was still high when the data access completed");
            end
            i_pend <= i_busy && !inst_valid;
            d_pend <= d_busy && !d_done;
            if (mem_en) d_pend_wr <= mem_wr;
        end
    end

    initial begin
        repeat (200 * N_OPS) @(posedge clk);
        $display("Watchdog expired after %0d cycles with an access still pending", 200 * N_OPS);
        $display("Something failed");
        $finish;
    end

    initial begin
        int idx;
        int chk_fails;
        bus_pkg::size_t sz;
        void'($urandom(31));
        rst = 1'b1;
        is_new_pc = 1'b0;
        pc = '0;
        mem_en = 1'b0;
        mem_wr = 1'b0;
        mem_size = bus_pkg::SIZE_WORD;
        mem_addr = '0;
        mem_wdata = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        quiet_check(6);

        // Both regions are written in full before anything reads them.
        for (int i = 0; i < FETCH_WORDS; i++) begin
            access(1'b1, bus_pkg::SIZE_WORD, lane_addr(i, bus_pkg::SIZE_WORD), $urandom);
        end
        for (int i = 0; i < FETCH_WORDS; i++) begin
            fetch(lane_addr(i, bus_pkg::SIZE_WORD), 1'b1);
        end
        for (int i = 0; i < DATA_WORDS; i++) begin
            idx = DATA_BASE + i;
            access(1'b1, bus_pkg::SIZE_WORD, lane_addr(idx, bus_pkg::SIZE_WORD), $urandom);
        end

        for (int i = 0; i < N_SUB; i++) begin
            idx = DATA_BASE + $urandom_range(0, DATA_WORDS - 1);
            sz = bus_pkg::size_t'($urandom_range(0, 1));
            access(1'b1, sz, lane_addr(idx, sz), $urandom);
            sz = bus_pkg::size_t'(i % 3);  // Loads cycle through all three sizes.
            access(1'b0, sz, lane_addr(idx, sz), '0);
        end

        for (int i = 0; i < N_PAIR; i++) begin
            idx = DATA_BASE + $urandom_range(0, DATA_WORDS - 1);
            fork
                fetch(lane_addr($urandom_range(0, FETCH_WORDS - 1), bus_pkg::SIZE_WORD), 1'b0);
                access(1'b0, bus_pkg::SIZE_WORD, lane_addr(idx, bus_pkg::SIZE_WORD), '0);
            join
            assert (data_done_t < inst_done_t) else begin
                errors++;
                $error("The fetch finished before the data access issued in the same cycle");
            end
        end

        fork
            for (int i = 0; i < N_MIX; i++) begin
                fetch(lane_addr($urandom_range(0, FETCH_WORDS - 1), bus_pkg::SIZE_WORD), 1'b0);
            end
            for (int i = 0; i < N_MIX; i++) begin
                repeat ($urandom_range(0, 3)) @(negedge clk);
                random_access();
            end
        join

        repeat (4) @(posedge clk);
        chk_fails = DUT.u_bus_arbiter.u_chk.fails;
        $display("Closing report: %0d testbench errors, %0d bus assertion failures",
                 errors, chk_fails);
        if (errors == 0 && chk_fails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
source/bus_pkg.sv
source/ctrl_pkg.sv
source/inst_fetch.sv
source/data_access.sv
source/bus_arbiter.sv
source/sram_mem.sv
source/mem_subsys_top.sv
test/mem_subsys_chk.sv
test/mem_subsys_tb.sv

// ==== Bender.yml ====
package:
  name: mem_subsys

sources:
  - files:
      - source/bus_pkg.sv
      - source/ctrl_pkg.sv
      - source/inst_fetch.sv
      - source/data_access.sv
      - source/bus_arbiter.sv
      - source/sram_mem.sv
      - source/mem_subsys_top.sv
  - target: test
    files:
      - test/mem_subsys_chk.sv
      - test/mem_subsys_tb.sv
